/* logic/access_decode.sv */
// Core access decoder
module access_decode (
	input logic rd_req,
	input logic wr_req,
	input logic [31:0] addr,
	input logic [31:0] wr_data,
	dc_req_if.decode req
);
	import dcache_pkg::*;

	core_addr_t core_addr;
	logic side_channel;

	assign core_addr = addr;

	// Bit 31 selects the register space, not served here
	assign side_channel = core_addr.space.uncached;

	always_comb begin
		req.addr = core_addr;
		req.rd = rd_req && !side_channel;
		req.wr = wr_req && !side_channel;
		req.uncached = (rd_req || wr_req) && side_channel;
	end

	// Word lands in both halves, the mask picks one
	always_comb begin
		req.wr_beat = {wr_data, wr_data};
		if (core_addr.cache.half) begin
			req.wr_mask = 8'hF0;
		end else begin
			req.wr_mask = 8'h0F;
		end
	end

	// The core presents one kind of access at a time
	always_comb begin
		assert final (!(req.rd && req.wr))
		else $error("access_decode: read and write requested together");
	end

endmodule

/* logic/cache_execute.sv */
// Cache lookup and bus request engine
module cache_execute (
	input logic clk,
	input logic arst_n,
	dc_req_if.exec req,
	dc_line_if.exec line,

	output logic fsabo_valid,
	output logic [dcache_pkg::BUS_MODE_W-1:0] fsabo_mode,
	output logic [dcache_pkg::BUS_DID_W-1:0] fsabo_did,
	output logic [dcache_pkg::BUS_DID_W-1:0] fsabo_subdid,
	output logic [dcache_pkg::BUS_ADDR_W-1:0] fsabo_addr,
	output logic [dcache_pkg::BUS_LEN_W-1:0] fsabo_len,
	output logic [dcache_pkg::BUS_DATA_W-1:0] fsabo_data,
	output logic [dcache_pkg::BUS_MASK_W-1:0] fsabo_mask,
	input logic fsabo_credit,

	input logic fsabi_valid,
	input logic [dcache_pkg::BUS_DID_W-1:0] fsabi_did,
	input logic [dcache_pkg::BUS_DID_W-1:0] fsabi_subdid,
	input logic [dcache_pkg::BUS_DATA_W-1:0] fsabi_data
);
	import dcache_pkg::*;

	logic [LINES-1:0] valid;
	logic [21:0] tags [LINES];
	logic [CREDIT_W-1:0] credits;
	logic fill_pending;
	logic [3:0] fill_index; // Line being filled
	logic [21:0] fill_tag;
	logic [2:0] fill_beat;
	logic fill_match;
	logic fill_last;
	logic start_read;
	logic start_write;

	assign line.hit = valid[req.addr.cache.index]
		&& (tags[req.addr.cache.index] == req.addr.cache.tag);
	assign line.credit_avail = (credits != '0);

	// One fill at a time, writes may pile up while credits last
	assign start_read = req.rd && !line.hit && !fill_pending && line.credit_avail;
	assign start_write = req.wr && line.credit_avail;

	assign fill_match = fsabi_valid && (fsabi_did == DID_CPU) && (fsabi_subdid == SUBDID_DCACHE);
	assign fill_last = (fill_beat == 3'(LINE_BEATS - 1));

	always_comb begin
		fsabo_valid = start_read || start_write;
		fsabo_mode = BUS_MODE_READ;
		fsabo_did = DID_CPU;
		fsabo_subdid = SUBDID_DCACHE;
		fsabo_addr = '0;
		fsabo_len = '0;
		fsabo_data = '0;
		fsabo_mask = '0;
		if (start_read) begin
			fsabo_addr = {req.addr.space.offset[30:6], 6'b0}; // Line aligned
			fsabo_len = BUS_LEN_W'(LINE_BEATS);
		end else if (start_write) begin
			fsabo_mode = BUS_MODE_WRITE;
			fsabo_addr = {req.addr.space.offset[30:3], 3'b0};
			fsabo_len = BUS_LEN_W'(1);
			fsabo_data = req.wr_beat;
			fsabo_mask = req.wr_mask;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0;
			credits <= CREDIT_W'(BUS_CREDITS);
			fill_pending <= 1'b0;
			fill_beat <= '0;
		end else begin
			credits <= credits + CREDIT_W'(fsabo_credit) - CREDIT_W'(fsabo_valid);
			if (start_read) begin
				fill_pending <= 1'b1;
				fill_beat <= '0;
			end else if (fill_match) begin
				fill_beat <= fill_beat + 3'd1;
				if (fill_last) begin
					valid[fill_index] <= 1'b1;
					fill_pending <= 1'b0;
				end else if (fill_beat == '0) begin
					valid[fill_index] <= 1'b0; // Old contents going away
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_read) begin
			fill_index <= req.addr.cache.index;
			fill_tag <= req.addr.cache.tag;
		end
		if (fill_match && fill_last) begin
			tags[fill_index] <= fill_tag;
		end
	end

	line_store u_line_store (
		.clk(clk),
		.fill_en(fill_match),
		.fill_index(fill_index),
		.fill_beat(fill_beat),
		.fill_data(fsabi_data),
		.wr_en(start_write && line.hit), // Write hit only, no allocate
		.wr_index(req.addr.cache.index),
		.wr_beat(req.addr.cache.beat),
		.wr_hi(req.addr.cache.half),
		.wr_word(req.wr_beat[31:0]),
		.rd_index(req.addr.cache.index),
		.rd_beat(req.addr.cache.beat),
		.rd_hi_word(line.word_hi),
		.rd_lo_word(line.word_lo)
	);

	// Bus returns no more credits than it was given; an underflow wraps above the limit too
	assert property (@(posedge clk) disable iff (!arst_n) credits <= CREDIT_W'(BUS_CREDITS))
	else $error("cache_execute: credit count out of range");

	// Beats for us only come back for the read we issued
	assert property (@(posedge clk) disable iff (!arst_n) fill_match |-> fill_pending)
	else $error("cache_execute: fill beat with no read outstanding");

endmodule

/* logic/dcache_ifs.sv */
// Data cache internal interfaces

// Decoded core access
interface dc_req_if;
	import dcache_pkg::*;

	logic rd; // Cacheable read
	logic wr; // Cacheable write
	logic uncached;
	core_addr_t addr;
	logic [BUS_DATA_W-1:0] wr_beat; // Write word in both halves
	logic [BUS_MASK_W-1:0] wr_mask;

	modport decode (output rd, wr, uncached, addr, wr_beat, wr_mask);
	modport exec (input rd, wr, addr, wr_beat, wr_mask);
	modport result (input rd, wr, uncached, addr);

endinterface

// Lookup outcome for the current access
interface dc_line_if;

	logic hit;
	logic credit_avail;
	logic [31:0] word_hi; // Addressed beat, upper word
	logic [31:0] word_lo;

	modport exec (output hit, credit_avail, word_hi, word_lo);
	modport result (input hit, credit_avail, word_hi, word_lo);

endinterface

/* logic/dcache_pkg.sv */
// Data cache shared definitions
package dcache_pkg;

	// Memory bus field widths
	localparam int BUS_MODE_W = 2;
	localparam int BUS_DID_W = 4;
	localparam int BUS_ADDR_W = 31;
	localparam int BUS_LEN_W = 4;
	localparam int BUS_DATA_W = 64;
	localparam int BUS_MASK_W = 8; // One bit per byte of a beat

	localparam logic [BUS_MODE_W-1:0] BUS_MODE_READ = 2'b00;
	localparam logic [BUS_MODE_W-1:0] BUS_MODE_WRITE = 2'b01;

	// Ids carried on our requests and matched on returning beats
	localparam logic [BUS_DID_W-1:0] DID_CPU = 4'h1;
	localparam logic [BUS_DID_W-1:0] SUBDID_DCACHE = 4'h2;

	localparam int BUS_CREDITS = 4;
	localparam int CREDIT_W = 3;

	// Cache geometry
	localparam int LINE_BEATS = 8;
	localparam int LINES = 16;

	// Address as the cache sees it
	typedef struct packed {
		logic [21:0] tag;
		logic [3:0] index;
		logic [2:0] beat;
		logic half; // Selects the high word of a beat
		logic [1:0] byte_off;
	} cache_addr_t;

	// Address as the address map sees it
	typedef struct packed {
		logic uncached; // Side-channel register space
		logic [BUS_ADDR_W-1:0] offset;
	} space_addr_t;

	typedef union packed {
		cache_addr_t cache;
		space_addr_t space;
	} core_addr_t;

endpackage

/* logic/dcache_top.sv */
// Write-through data cache
module dcache_top (
	input logic clk,
	input logic arst_n,

	// Core data port
	input logic [31:0] addr,
	input logic rd_req,
	input logic wr_req,
	input logic [31:0] wr_data,
	output logic rw_wait,
	output logic [31:0] rd_data,

	// Memory bus
	output logic fsabo_valid,
	output logic [dcache_pkg::BUS_MODE_W-1:0] fsabo_mode,
	output logic [dcache_pkg::BUS_DID_W-1:0] fsabo_did,
	output logic [dcache_pkg::BUS_DID_W-1:0] fsabo_subdid,
	output logic [dcache_pkg::BUS_ADDR_W-1:0] fsabo_addr,
	output logic [dcache_pkg::BUS_LEN_W-1:0] fsabo_len,
	output logic [dcache_pkg::BUS_DATA_W-1:0] fsabo_data,
	output logic [dcache_pkg::BUS_MASK_W-1:0] fsabo_mask,
	input logic fsabo_credit,
	input logic fsabi_valid,
	input logic [dcache_pkg::BUS_DID_W-1:0] fsabi_did,
	input logic [dcache_pkg::BUS_DID_W-1:0] fsabi_subdid,
	input logic [dcache_pkg::BUS_DATA_W-1:0] fsabi_data
);

	dc_req_if req_bus ();
	dc_line_if line_bus ();

	access_decode u_decode (
		.rd_req(rd_req),
		.wr_req(wr_req),
		.addr(addr),
		.wr_data(wr_data),
		.req(req_bus.decode)
	);

	cache_execute u_execute (
		.clk(clk),
		.arst_n(arst_n),
		.req(req_bus.exec),
		.line(line_bus.exec),
		.fsabo_valid(fsabo_valid),
		.fsabo_mode(fsabo_mode),
		.fsabo_did(fsabo_did),
		.fsabo_subdid(fsabo_subdid),
		.fsabo_addr(fsabo_addr),
		.fsabo_len(fsabo_len),
		.fsabo_data(fsabo_data),
		.fsabo_mask(fsabo_mask),
		.fsabo_credit(fsabo_credit),
		.fsabi_valid(fsabi_valid),
		.fsabi_did(fsabi_did),
		.fsabi_subdid(fsabi_subdid),
		.fsabi_data(fsabi_data)
	);

	read_result u_result (
		.req(req_bus.result),
		.line(line_bus.result),
		.rw_wait(rw_wait),
		.rd_data(rd_data)
	);

endmodule

/* logic/line_store.sv */
// Cache data arrays
module line_store (
	input logic clk,
	input logic fill_en,
	input logic [3:0] fill_index,
	input logic [2:0] fill_beat,
	input logic [63:0] fill_data,
	input logic wr_en,
	input logic [3:0] wr_index,
	input logic [2:0] wr_beat,
	input logic wr_hi,
	input logic [31:0] wr_word,
	input logic [3:0] rd_index,
	input logic [2:0] rd_beat,
	output logic [31:0] rd_hi_word,
	output logic [31:0] rd_lo_word
);
	import dcache_pkg::*;

	// Indexed by {line, beat}
	logic [31:0] data_hi [LINES * LINE_BEATS];
	logic [31:0] data_lo [LINES * LINE_BEATS];

	always_ff @(posedge clk) begin
		if (fill_en) begin
			data_hi[{fill_index, fill_beat}] <= fill_data[63:32];
			data_lo[{fill_index, fill_beat}] <= fill_data[31:0];
		end
		if (wr_en && wr_hi) begin
			data_hi[{wr_index, wr_beat}] <= wr_word;
		end
		if (wr_en && !wr_hi) begin
			data_lo[{wr_index, wr_beat}] <= wr_word;
		end
	end

	assign rd_hi_word = data_hi[{rd_index, rd_beat}];
	assign rd_lo_word = data_lo[{rd_index, rd_beat}];

	// Core is stalled on its read for the whole fill, so no write can land then
	assert property (@(posedge clk) !(fill_en && wr_en))
	else $error("line_store: fill and write hit in the same cycle");

endmodule

/* logic/read_result.sv */
// Read data and stall logic
module read_result (
	dc_req_if.result req,
	dc_line_if.result line,
	output logic rw_wait,
	output logic [31:0] rd_data
);

	logic read_miss;
	logic write_blocked;

	assign read_miss = req.rd && !line.hit;
	assign write_blocked = req.wr && !line.credit_avail;

	// Register space is never answered, so the core waits
	assign rw_wait = read_miss || write_blocked || req.uncached;

	always_comb begin
		if (req.uncached) begin
			rd_data = 32'h0;
		end else if (req.addr.cache.half) begin
			rd_data = line.word_hi;
		end else begin
			rd_data = line.word_lo;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f tb.f -o dcache_sim \
	&& ./obj_dir/dcache_sim > sim.log 2>&1
grep -qx "TEST OK" sim.log && echo "Simulation passed" || { cat sim.log; exit 1; }

/* tb.f */
logic/dcache_pkg.sv
logic/dcache_ifs.sv
logic/line_store.sv
logic/access_decode.sv
logic/cache_execute.sv
logic/read_result.sv
logic/dcache_top.sv
verification/bus_memory_model.sv
verification/dcache_tb.sv

/* verification/bus_memory_model.sv */
// Memory bus responder
module bus_memory_model (
	input logic clk,
	input logic arst_n,
	input logic hold, // Keeps credits back while high
	input logic fsabo_valid,
	input logic [dcache_pkg::BUS_MODE_W-1:0] fsabo_mode,
	input logic [dcache_pkg::BUS_ADDR_W-1:0] fsabo_addr,
	input logic [dcache_pkg::BUS_DATA_W-1:0] fsabo_data,
	input logic [dcache_pkg::BUS_MASK_W-1:0] fsabo_mask,
	output logic fsabo_credit,
	output logic fsabi_valid,
	output logic [dcache_pkg::BUS_DID_W-1:0] fsabi_did,
	output logic [dcache_pkg::BUS_DID_W-1:0] fsabi_subdid,
	output logic [dcache_pkg::BUS_DATA_W-1:0] fsabi_data
);
	import dcache_pkg::*;

	logic [63:0] mem [512]; // 4 KiB as beats, loaded by the testbench
	int owed; // Credits spent and not yet returned
	int next_owed;
	int credit_wait;
	int beats_left;
	int beat_wait;
	logic [8:0] beat_addr;

	assign fsabi_did = DID_CPU;
	assign fsabi_subdid = SUBDID_DCACHE;
	assign next_owed = owed + int'(fsabo_valid) - int'(fsabo_credit);

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			owed <= 0;
			credit_wait <= 0;
			fsabo_credit <= 1'b0;
			fsabi_valid <= 1'b0;
			beats_left <= 0;
			beat_wait <= 0;
		end else begin
			owed <= next_owed;
			if (fsabo_valid || fsabo_credit) begin
				credit_wait <= 3;
			end else if (credit_wait != 0) begin
				credit_wait <= credit_wait - 1;
			end
			fsabo_credit <= !hold && next_owed != 0 && credit_wait == 0
				&& !fsabo_valid && !fsabo_credit;
			fsabi_valid <= 1'b0;
			if (fsabo_valid && fsabo_mode == BUS_MODE_READ) begin
				beat_addr <= fsabo_addr[11:3];
				beats_left <= LINE_BEATS;
				beat_wait <= 3; // Read latency
			end else if (beats_left != 0 && beat_wait != 0) begin
				beat_wait <= beat_wait - 1;
			end else if (beats_left != 0) begin
				fsabi_valid <= 1'b1;
				fsabi_data <= mem[beat_addr];
				beat_addr <= beat_addr + 9'd1;
				beats_left <= beats_left - 1;
				if (beats_left == LINE_BEATS - 2) begin
					beat_wait <= 1; // Gap after the third beat
				end
			end
			if (fsabo_valid && fsabo_mode == BUS_MODE_WRITE) begin
				for (int b = 0; b < BUS_MASK_W; b++) begin
					if (fsabo_mask[b]) begin
						mem[fsabo_addr[11:3]][8*b +: 8] <= fsabo_data[8*b +: 8];
					end
				end
			end
		end
	end

endmodule

/* verification/dcache_tb.sv */
// Data cache testbench
module dcache_tb;
	import dcache_pkg::*;

	typedef enum int {OP_READ, OP_WRITE, OP_UNCACHED} op_e;
	typedef struct {
		op_e op;
		logic [31:0] a;
		logic [31:0] d;
		int bus_rd; // Bus reads expected
	} entry_t;

	logic clk;
	logic arst_n;
	logic [31:0] addr;
	logic rd_req;
	logic wr_req;
	logic [31:0] wr_data;
	logic rw_wait;
	logic [31:0] rd_data;
	logic hold;
	logic fsabo_valid;
	logic [BUS_MODE_W-1:0] fsabo_mode;
	logic [BUS_DID_W-1:0] fsabo_did;
	logic [BUS_DID_W-1:0] fsabo_subdid;
	logic [BUS_ADDR_W-1:0] fsabo_addr;
	logic [BUS_LEN_W-1:0] fsabo_len;
	logic [BUS_DATA_W-1:0] fsabo_data;
	logic [BUS_MASK_W-1:0] fsabo_mask;
	logic fsabo_credit;
	logic fsabi_valid;
	logic [BUS_DID_W-1:0] fsabi_did;
	logic [BUS_DID_W-1:0] fsabi_subdid;
	logic [BUS_DATA_W-1:0] fsabi_data;

	int errors = 0;
	int rd_count = 0;
	int wr_count = 0;
	logic [30:0] last_rd_addr;
	logic [3:0] last_rd_len;
	logic [30:0] last_wr_addr;
	logic [63:0] last_wr_data;
	logic [7:0] last_wr_mask;
	logic [63:0] shadow [512];
	logic [31:0] lcg_state = 32'h4115_05c6;

	// Operation, address, write data, bus reads expected
	entry_t rows [11] = '{
		'{OP_READ, 32'h0000_0104, 32'h0, 1}, // Miss and fill
		'{OP_READ, 32'h0000_0138, 32'h0, 0},
		'{OP_WRITE, 32'h0000_0108, 32'hA5A5_1234, 0},
		'{OP_READ, 32'h0000_0108, 32'h0, 0},
		'{OP_WRITE, 32'h0000_010C, 32'h0BAD_CAFE, 0},
		'{OP_READ, 32'h0000_010C, 32'h0, 0},
		'{OP_WRITE, 32'h0000_0A20, 32'h1357_9BDF, 0}, // Line not resident
		'{OP_READ, 32'h0000_0A20, 32'h0, 1},
		'{OP_READ, 32'h0000_0E24, 32'h0, 1}, // Same index, evicts 0xA00
		'{OP_READ, 32'h0000_0A20, 32'h0, 1},
		'{OP_UNCACHED, 32'h8000_0100, 32'h0, 0}
	};

	dcache_top uut (.*);
	bus_memory_model mem_model (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Bus request monitor
	always @(posedge clk) begin
		if (arst_n && fsabo_valid) begin
			compare_hex("fsabo_did", DID_CPU, fsabo_did);
			compare_hex("fsabo_subdid", SUBDID_DCACHE, fsabo_subdid);
			if (fsabo_mode == BUS_MODE_READ) begin
				rd_count <= rd_count + 1;
				last_rd_addr <= fsabo_addr;
				last_rd_len <= fsabo_len;
			end else begin
				compare_hex("fsabo_mode", BUS_MODE_WRITE, fsabo_mode);
				wr_count <= wr_count + 1;
				last_wr_addr <= fsabo_addr;
				last_wr_data <= fsabo_data;
				last_wr_mask <= fsabo_mask;
			end
		end
	end

	task automatic compare_hex(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			errors++;
			$display("Error: %s expected %h got %h", name, exp, act);
		end
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge clk);
		while (rw_wait && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (rw_wait) begin
			errors++;
			$display("rw_wait stayed high for 100 cycles");
		end
	endtask

	task automatic wait_credits_home();
		int n;
		n = 0;
		@(negedge clk);
		while ((mem_model.owed != 0 || fsabo_credit) && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (mem_model.owed != 0) begin
			errors++;
			$display("Bus credits were not all returned within 100 cycles");
		end
	endtask

	task automatic apply_entry(input op_e op, input logic [31:0] a, input logic [31:0] d,
		input int bus_rd);
		int rd0;
		int wr0;
		logic [31:0] exp_word;
		rd0 = rd_count;
		wr0 = wr_count;
		@(posedge clk);
		rd_req <= (op != OP_WRITE);
		wr_req <= (op == OP_WRITE);
		addr <= a;
		wr_data <= d;
		if (op == OP_UNCACHED) begin
			for (int n = 0; n < 20; n++) begin
				@(negedge clk);
				compare_hex("rw_wait", 1, rw_wait);
				compare_hex("rd_data", 0, rd_data);
			end
		end else begin
			wait_ready();
			exp_word = a[2] ? shadow[a[11:3]][63:32] : shadow[a[11:3]][31:0];
			if (op == OP_READ) begin
				compare_hex("rd_data", exp_word, rd_data);
			end else if (a[2]) begin
				shadow[a[11:3]][63:32] = d;
			end else begin
				shadow[a[11:3]][31:0] = d;
			end
		end
		@(posedge clk);
		rd_req <= 1'b0;
		wr_req <= 1'b0;
		@(negedge clk);
		compare_hex("rw_wait", 0, rw_wait);
		compare_hex("rd_count", bus_rd, rd_count - rd0);
		compare_hex("wr_count", op == OP_WRITE, wr_count - wr0);
		if (bus_rd != 0) begin
			compare_hex("fsabo_addr", {a[30:6], 6'b0}, last_rd_addr);
			compare_hex("fsabo_len", LINE_BEATS, last_rd_len);
		end
		if (op == OP_WRITE) begin
			compare_hex("fsabo_addr", {a[30:3], 3'b0}, last_wr_addr);
			compare_hex("fsabo_data", {d, d}, last_wr_data);
			compare_hex("fsabo_mask", a[2] ? 8'hF0 : 8'h0F, last_wr_mask);
		end
	endtask

	initial begin
		int wr0;
		logic [31:0] late_addr;
		logic [31:0] late_word;
		arst_n = 1'b0;
		addr = 32'h0;
		rd_req = 1'b0;
		wr_req = 1'b0;
		wr_data = 32'h0;
		hold = 1'b0;
		for (int i = 0; i < 512; i++) begin
			shadow[i] = {lcg_next(), lcg_next()};
			mem_model.mem[i] = shadow[i];
		end
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		for (int n = 0; n < 5; n++) begin
			@(negedge clk);
			compare_hex("fsabo_valid", 0, fsabo_valid);
			compare_hex("rw_wait", 0, rw_wait);
		end
		foreach (rows[i]) begin
			apply_entry(rows[i].op, rows[i].a, rows[i].d, rows[i].bus_rd);
		end

		// Use up every credit while the bus keeps them
		wait_credits_home();
		@(posedge clk);
		hold <= 1'b1;
		for (int n = 0; n < BUS_CREDITS; n++) begin
			apply_entry(OP_WRITE, 32'h0000_0100 + 32'(4 * n), lcg_next(), 0);
		end
		late_addr = 32'h0000_0110;
		late_word = lcg_next();
		wr0 = wr_count;
		@(posedge clk);
		wr_req <= 1'b1;
		addr <= late_addr;
		wr_data <= late_word;
		for (int n = 0; n < 10; n++) begin
			@(negedge clk);
			compare_hex("rw_wait", 1, rw_wait);
		end
		compare_hex("wr_count", wr0, wr_count);
		@(posedge clk);
		hold <= 1'b0;
		wait_ready();
		shadow[late_addr[11:3]][31:0] = late_word;
		@(posedge clk);
		wr_req <= 1'b0;
		@(negedge clk);
		compare_hex("wr_count", wr0 + 1, wr_count);
		apply_entry(OP_READ, late_addr, 32'h0, 0);

		$display("Checks finished with %0d errors", errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
